//--- flist.f
hdl/irig_pkg.sv
hdl/symbol_timer.sv
hdl/frame_sequencer.sv
hdl/frame_builder.sv
hdl/symbol_shaper.sv
hdl/irig_b_encoder.sv
dv/irig_b_properties.sv
dv/irig_b_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the IRIG-B encoder testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module irig_b_tb -f flist.f -o irig_b_sim

# Raised error limit lets the run reach its summary after an assertion error
output=$(./obj_dir/irig_b_sim +verilator+error+limit+1000 2>&1 || true)
echo "$output"

if grep -q 'All tests passed!' <<< "$output"; then
	exit 0
fi
exit 1

//--- dv/irig_b_tb.sv
/*
 * Testbench for the IRIG-B000 encoder.
 * Sends fixed and random BCD times, rebuilds each frame from the pulse
 * widths on bcode and compares it with the time present at frame start.
 */
`timescale 1ns/1ps

module irig_b_tb;

	import irig_pkg::*;

	localparam int SYMBOL_CLKS = 20;
	localparam int ZERO_CLKS   = 4;
	localparam int ONE_CLKS    = 10;
	localparam int MARK_CLKS   = 16;
	localparam int FRAME_CLKS  = SYMBOL_CLKS * FRAME_SYMBOLS;
	// Frames waited for by the tests, 1 + 2 fixed, 3 x 2 random, 1 stop
	localparam int TEST_FRAMES = 10;

	logic       clk;
	logic       rst_n;
	logic       enable;
	irig_time_t time_in;
	logic       bcode;
	logic       pps;

	integer      seed = 73516;
	int unsigned rnd [4];
	string       test_name;
	int          test_start_errors;
	int          tests_run;
	int          tests_failed;
	bit          expect_idle;

	// --------------------------------------------------
	// Decoder state
	// --------------------------------------------------
	int                       errors;
	int                       frames_done;
	int                       high_len;
	int                       pos;
	bit                       synced;
	logic [FRAME_SYMBOLS-1:0] ones;
	irig_time_t               frame_expect;
	irig_time_t               frame_got;

	irig_b_encoder #(
		.SYMBOL_CLKS(SYMBOL_CLKS),
		.ZERO_CLKS  (ZERO_CLKS),
		.ONE_CLKS   (ONE_CLKS),
		.MARK_CLKS  (MARK_CLKS)
	) i_dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.enable (enable),
		.time_in(time_in),
		.bcode  (bcode),
		.pps    (pps)
	);

	// Output checks, placed inside the encoder
	bind irig_b_encoder irig_b_properties #(
		.SYMBOL_CLKS(SYMBOL_CLKS),
		.ZERO_CLKS  (ZERO_CLKS),
		.ONE_CLKS   (ONE_CLKS),
		.MARK_CLKS  (MARK_CLKS)
	) i_properties (
		.clk  (clk),
		.rst_n(rst_n),
		.run  (run),
		.bcode(bcode),
		.pps  (pps)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Decoder errors plus failed output properties
	function automatic int error_count();
		return errors + i_dut.i_properties.fail_count;
	endfunction

	// Day, hour, minute, second in binary to the BCD record
	function automatic irig_time_t make_time(int d, int h, int m, int s);
		irig_time_t t;
		t.days_bcd    = {2'(d / 100), 4'(d / 10 % 10), 4'(d % 10)};
		t.hours_bcd   = {2'(h / 10), 4'(h % 10)};
		t.minutes_bcd = {3'(m / 10), 4'(m % 10)};
		t.seconds_bcd = {3'(s / 10), 4'(s % 10)};
		return t;
	endfunction

	// Frame rebuilt by the position table, digits LSB first
	task automatic check_frame();
		frame_got.seconds_bcd = {ones[8:6], ones[4:1]};
		frame_got.minutes_bcd = {ones[17:15], ones[13:10]};
		frame_got.hours_bcd   = {ones[26:25], ones[23:20]};
		frame_got.days_bcd    = {ones[41:40], ones[38:35], ones[33:30]};
		assert (frame_got == frame_expect) else begin
			$display("MISMATCH %s: expected %03h %02h:%02h:%02h, actual %03h %02h:%02h:%02h",
				test_name, frame_expect.days_bcd, frame_expect.hours_bcd,
				frame_expect.minutes_bcd, frame_expect.seconds_bcd, frame_got.days_bcd,
				frame_got.hours_bcd, frame_got.minutes_bcd, frame_got.seconds_bcd);
			errors++;
		end
		frames_done++;
	endtask

	// Classify one finished high stretch
	task automatic end_symbol(int width);
		bit is_mark;
		bit mark_pos;
		is_mark  = (width == MARK_CLKS);
		mark_pos = (pos == 0) || (pos % 10 == 9);
		assert (width == ZERO_CLKS || width == ONE_CLKS || width == MARK_CLKS) else begin
			$display("%s: bcode was high for %0d cycles, no legal symbol", test_name, width);
			errors++;
		end
		if (synced) begin
			assert (is_mark == mark_pos) else begin
				$display("MISMATCH %s: position %0d expected marker %0d, actual marker %0d",
					test_name, pos, mark_pos, is_mark);
				errors++;
			end
			ones[pos] = (width == ONE_CLKS);
			pos++;
			if (pos == FRAME_SYMBOLS) begin
				check_frame();
				synced = 1'b0;
			end
		end
	endtask

	// Sampled mid-cycle, away from the DUT's clock edge
	always @(negedge clk) begin
		if (expect_idle) begin
			assert (!bcode && !pps) else begin
				$display("%s: bcode or pps high while the encoder is idle", test_name);
				errors++;
			end
		end
		// Frame start; expected time is the one present now
		if (pps) begin
			pos          = 0;
			synced       = 1'b1;
			frame_expect = time_in;
		end
		if (bcode) begin
			high_len++;
		end else if (high_len != 0) begin
			end_symbol(high_len);
			high_len = 0;
		end
	end

	task automatic start_test(string name);
		test_name         = name;
		test_start_errors = error_count();
	endtask

	task automatic finish_test();
		int test_errors;
		test_errors = error_count() - test_start_errors;
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: passed", test_name);
		end else begin
			tests_failed++;
			$display("%s: FAILED, %0d errors", test_name, test_errors);
		end
	endtask

	task automatic wait_frames(int n);
		int target;
		target = frames_done + n;
		while (frames_done < target) begin
			@(posedge clk);
		end
	endtask

	// New time early in a frame, so the next frame takes it
	task automatic apply_time(irig_time_t t);
		@(posedge pps);
		@(posedge clk);
		#10 time_in = t;
	endtask

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin
		rst_n       = 1'b0;
		enable      = 1'b0;
		time_in     = '0;
		expect_idle = 1'b1;

		start_test("reset_state");
		repeat (10) @(posedge clk);
		#10 rst_n = 1'b1;
		repeat (2 * SYMBOL_CLKS) @(posedge clk);
		finish_test();

		start_test("fixed_day001_000000");
		#10;
		expect_idle = 1'b0;
		time_in     = make_time(1, 0, 0, 0);
		enable      = 1'b1;
		wait_frames(1);
		finish_test();

		// Frame in flight keeps the old time
		start_test("fixed_day366_235959");
		apply_time(make_time(366, 23, 59, 59));
		wait_frames(2);
		finish_test();

		for (int i = 0; i < 3; i++) begin
			start_test($sformatf("random_time_%0d", i));
			for (int k = 0; k < 4; k++) begin
				rnd[k] = {$random(seed)};
			end
			apply_time(make_time(rnd[0] % 366 + 1, rnd[1] % 24, rnd[2] % 60, rnd[3] % 60));
			wait_frames(2);
			finish_test();
		end

		// Enable dropped at symbol 37, frame still runs to its end
		start_test("stop_mid_frame");
		@(posedge pps);
		repeat (37 * SYMBOL_CLKS) @(posedge clk);
		#10 enable = 1'b0;
		wait_frames(1);
		expect_idle = 1'b1;
		repeat (5 * SYMBOL_CLKS) @(posedge clk);
		finish_test();

		$display("Tests run %0d, passed %0d, failed %0d",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0 && error_count() == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Watchdog, all test frames plus two spare
	initial begin
		repeat ((TEST_FRAMES + 2) * FRAME_CLKS) @(posedge clk);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Test failures found");
		$finish;
	end

endmodule

//--- dv/irig_b_properties.sv
/*
 * Concurrent checks on the encoder's serial output, bound into the top.
 * Measures each high stretch of bcode, the spacing of rising edges and
 * the symbol index from pps, then checks widths, markers and idle level.
 */
`timescale 1ns/1ps

module irig_b_properties #(
	parameter int SYMBOL_CLKS = 20,
	parameter int ZERO_CLKS   = 4,
	parameter int ONE_CLKS    = 10,
	parameter int MARK_CLKS   = 16
) (
	input logic clk,
	input logic rst_n,
	input logic run,
	input logic bcode,
	input logic pps
);

	logic bcode_q;
	logic rise;
	logic fall;
	int   high_len;
	int   last_width;
	int   rise_gap;
	int   symbol_idx;
	// Number of failed properties so far
	int   fail_count;

	assign rise = bcode && !bcode_q;
	assign fall = !bcode && bcode_q;

	// --------------------------------------------------
	// Observers
	// --------------------------------------------------

	// Gap counter gives up after two periods, so idle gaps go unchecked
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bcode_q    <= 1'b0;
			high_len   <= 0;
			last_width <= 0;
			rise_gap   <= 0;
			symbol_idx <= 0;
		end else begin
			bcode_q  <= bcode;
			high_len <= bcode ? high_len + 1 : 0;
			if (fall) begin
				last_width <= high_len;
			end
			if (rise) begin
				rise_gap <= 1;
			end else if (rise_gap == 2 * SYMBOL_CLKS) begin
				rise_gap <= 0;
			end else if (rise_gap != 0) begin
				rise_gap <= rise_gap + 1;
			end
			// Symbol index restarts at the on-time edge
			if (pps) begin
				symbol_idx <= 0;
			end else if (fall) begin
				symbol_idx <= symbol_idx + 1;
			end
		end
	end

	// --------------------------------------------------
	// Properties
	// --------------------------------------------------

	// Line low during reset and one clock after the sequencer stops
	assert property (@(posedge clk) !rst_n |-> !bcode && !pps)
		else begin
			fail_count++;
			$error("bcode or pps high during reset");
		end
	assert property (@(posedge clk) disable iff (!rst_n) !run |=> !bcode && !pps)
		else begin
			fail_count++;
			$error("bcode or pps high while the sequencer is idle");
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		fall |-> (high_len == ZERO_CLKS || high_len == ONE_CLKS || high_len == MARK_CLKS))
		else begin
			fail_count++;
			$error("bcode high stretch of %0d clocks is no symbol width", high_len);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		(rise && rise_gap != 0) |-> rise_gap == SYMBOL_CLKS)
		else begin
			fail_count++;
			$error("symbol period of %0d clocks", rise_gap);
		end

	// Reference marker after pps and position markers every tenth symbol
	assert property (@(posedge clk) disable iff (!rst_n)
		(fall && (symbol_idx == 0 || symbol_idx % 10 == 9)) |-> high_len == MARK_CLKS)
		else begin
			fail_count++;
			$error("symbol %0d is not a marker", symbol_idx);
		end

	// Double marker at the frame boundary
	assert property (@(posedge clk) disable iff (!rst_n)
		(pps && last_width != 0) |-> last_width == MARK_CLKS)
		else begin
			fail_count++;
			$error("symbol before pps is not a marker");
		end

	// pps only on the first high cycle of a symbol, so one clock wide
	assert property (@(posedge clk) disable iff (!rst_n) pps |-> rise)
		else begin
			fail_count++;
			$error("pps high away from the rising edge of the reference marker");
		end

endmodule

//--- hdl/irig_b_encoder.sv
/*
 * IRIG-B000 time-code encoder, top level.
 * Takes a BCD time of year and sends it as a 100-symbol DC level-shift
 * frame on bcode, with a one-clock pps pulse at each frame's on-time edge.
 */
`timescale 1ns/1ps

module irig_b_encoder #(
	parameter int SYMBOL_CLKS = 500000,
	parameter int ZERO_CLKS   = SYMBOL_CLKS * 2 / 10,
	parameter int ONE_CLKS    = SYMBOL_CLKS * 5 / 10,
	parameter int MARK_CLKS   = SYMBOL_CLKS * 8 / 10
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 enable,
	input  irig_pkg::irig_time_t time_in,
	output logic                 bcode,
	output logic                 pps
);

	import irig_pkg::*;

	localparam int CNT_W = $clog2(SYMBOL_CLKS);

	// --------------------------------------------------
	// Internal nets
	// --------------------------------------------------
	logic                 run;
	logic [CNT_W-1:0]     count;
	logic                 symbol_end;
	logic [POS_WIDTH-1:0] position;
	irig_time_t           frame_time;
	symbol_e              symbol;

	// Clock count within the current symbol
	symbol_timer #(
		.SYMBOL_CLKS(SYMBOL_CLKS)
	) i_symbol_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.count     (count),
		.symbol_end(symbol_end)
	);

	// Frame start, position walk and time latch
	frame_sequencer i_frame_sequencer (
		.clk       (clk),
		.rst_n     (rst_n),
		.enable    (enable),
		.time_in   (time_in),
		.symbol_end(symbol_end),
		.run       (run),
		.position  (position),
		.frame_time(frame_time)
	);

	frame_builder i_frame_builder (
		.position  (position),
		.frame_time(frame_time),
		.symbol    (symbol)
	);

	// Pulse-width drawing of each symbol
	symbol_shaper #(
		.SYMBOL_CLKS(SYMBOL_CLKS),
		.ZERO_CLKS  (ZERO_CLKS),
		.ONE_CLKS   (ONE_CLKS),
		.MARK_CLKS  (MARK_CLKS)
	) i_symbol_shaper (
		.clk     (clk),
		.rst_n   (rst_n),
		.run     (run),
		.count   (count),
		.symbol  (symbol),
		.position(position),
		.bcode   (bcode),
		.pps     (pps)
	);

endmodule

//--- hdl/symbol_shaper.sv
/*
 * Draws one IRIG-B symbol per period as a registered high pulse.
 * The line is high while the count is below the symbol's high time,
 * then low for the rest of the period. Also marks the on-time edge.
 */
`timescale 1ns/1ps

module symbol_shaper #(
	parameter int SYMBOL_CLKS = 500000,
	parameter int ZERO_CLKS   = SYMBOL_CLKS * 2 / 10,
	parameter int ONE_CLKS    = SYMBOL_CLKS * 5 / 10,
	parameter int MARK_CLKS   = SYMBOL_CLKS * 8 / 10
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           run,
	input  logic [$clog2(SYMBOL_CLKS)-1:0] count,
	input  irig_pkg::symbol_e              symbol,
	input  logic [irig_pkg::POS_WIDTH-1:0] position,
	output logic                           bcode,
	output logic                           pps
);

	import irig_pkg::*;

	localparam int CNT_W = $clog2(SYMBOL_CLKS);

	logic [CNT_W-1:0] high_clks;

	// High time for the symbol being drawn
	always_comb begin
		case (symbol)
			SYM_ONE:  high_clks = CNT_W'(ONE_CLKS);
			SYM_MARK: high_clks = CNT_W'(MARK_CLKS);
			default:  high_clks = CNT_W'(ZERO_CLKS);
		endcase
	end

	// Output level, one clock behind the count
	// pps lines up with the first high cycle of the reference marker
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bcode <= 1'b0;
			pps   <= 1'b0;
		end else begin
			bcode <= run && (count < high_clks);
			pps   <= run && (count == '0) && (position == '0);
		end
	end

endmodule

//--- hdl/frame_builder.sv
/*
 * IRIG-B000 frame map.
 * Turns a symbol position and the latched time into the symbol to send.
 * Purely combinational; the shaper registers the result.
 */
`timescale 1ns/1ps

module frame_builder (
	input  logic [irig_pkg::POS_WIDTH-1:0] position,
	input  irig_pkg::irig_time_t           frame_time,
	output irig_pkg::symbol_e              symbol
);

	import irig_pkg::*;

	// One bit per frame position
	logic [FRAME_SYMBOLS-1:0] mark_map;
	logic [FRAME_SYMBOLS-1:0] one_map;

	// --------------------------------------------------
	// Marker positions
	// --------------------------------------------------

	// Reference marker at 0, position markers at 9, 19, ... 99
	always_comb begin
		mark_map    = '0;
		mark_map[0] = 1'b1;
		for (int i = 9; i < FRAME_SYMBOLS; i += 10) begin
			mark_map[i] = 1'b1;
		end
	end

	// --------------------------------------------------
	// BCD data positions
	// --------------------------------------------------

	// Each digit goes out least significant bit first
	// Separator positions 5, 14, 24, 34 stay zero
	always_comb begin
		one_map = '0;

		// Seconds
		one_map[4:1]   = frame_time.seconds_bcd[3:0];
		one_map[8:6]   = frame_time.seconds_bcd[6:4];

		// Minutes
		one_map[13:10] = frame_time.minutes_bcd[3:0];
		one_map[17:15] = frame_time.minutes_bcd[6:4];

		// Hours, tens digit only 2 bits
		one_map[23:20] = frame_time.hours_bcd[3:0];
		one_map[26:25] = frame_time.hours_bcd[5:4];

		// Days, hundreds digit after the marker at 39
		one_map[33:30] = frame_time.days_bcd[3:0];
		one_map[38:35] = frame_time.days_bcd[7:4];
		one_map[41:40] = frame_time.days_bcd[9:8];

		// Control bits and binary seconds from 42 on are sent as zero
	end

	// --------------------------------------------------
	// Symbol select
	// --------------------------------------------------
	always_comb begin
		if (mark_map[position]) begin
			symbol = SYM_MARK;
		end else if (one_map[position]) begin
			symbol = SYM_ONE;
		end else begin
			symbol = SYM_ZERO;
		end
	end

endmodule

//--- hdl/frame_sequencer.sv
/*
 * Frame sequencer FSM for the IRIG-B encoder.
 * Starts a frame when enable is seen in idle, walks the 100 symbol
 * positions on each symbol end, and stops only at a frame boundary.
 * The time input is latched at every frame start.
 */
`timescale 1ns/1ps

module frame_sequencer (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            enable,
	input  irig_pkg::irig_time_t            time_in,
	input  logic                            symbol_end,
	output logic                            run,
	output logic [irig_pkg::POS_WIDTH-1:0]  position,
	output irig_pkg::irig_time_t            frame_time
);

	import irig_pkg::*;

	localparam logic [POS_WIDTH-1:0] LAST_POS = POS_WIDTH'(FRAME_SYMBOLS - 1);

	seq_state_e state;
	logic       frame_last;
	logic       load_time;

	// Final symbol of the frame is ending this clock
	assign frame_last = symbol_end && (position == LAST_POS);

	// --------------------------------------------------
	// State and position
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= SEQ_IDLE;
			position <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					position <= '0;
					if (enable) begin
						state <= SEQ_LOAD;
					end
				end
				// One clock to take the time before the first symbol
				SEQ_LOAD: begin
					position <= '0;
					state    <= SEQ_RUN;
				end
				SEQ_RUN: begin
					if (frame_last) begin
						position <= '0;
						// Leave only at the wrap from 99 to 0
						if (!enable) begin
							state <= SEQ_IDLE;
						end
					end else if (symbol_end) begin
						position <= position + 1'b1;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	assign run = (state == SEQ_RUN);

	// --------------------------------------------------
	// Time latch
	// --------------------------------------------------

	// New time takes effect only at a frame start
	assign load_time = (state == SEQ_LOAD) || (state == SEQ_RUN && frame_last);

	always_ff @(posedge clk) begin
		if (load_time) begin
			frame_time <= time_in;
		end
	end

endmodule

//--- hdl/symbol_timer.sv
/*
 * Clock counter for one IRIG-B symbol period.
 * Counts while run is high, wraps at SYMBOL_CLKS, and flags the last
 * clock of each period so the sequencer can step the position.
 */
`timescale 1ns/1ps

module symbol_timer #(
	parameter int SYMBOL_CLKS = 500000
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           run,
	output logic [$clog2(SYMBOL_CLKS)-1:0] count,
	output logic                           symbol_end
);

	localparam int CNT_W = $clog2(SYMBOL_CLKS);

	// Last count of a symbol period
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(SYMBOL_CLKS - 1);

	logic at_last;

	assign at_last = (count == LAST_CNT);

	// Period counter
	// Held at zero while idle so each frame starts on a clean period
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (!run || at_last) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// One clock wide, on the clock that wraps the count
	assign symbol_end = run && at_last;

endmodule

//--- hdl/irig_pkg.sv
/*
 * Shared types and constants for the IRIG-B000 encoder.
 * Holds the symbol and sequencer state enums and the BCD time record
 * carried from the time input through the frame latch to the builder.
 */
package irig_pkg;

	// --------------------------------------------------
	// Frame geometry
	// --------------------------------------------------

	// One frame is one second at 100 symbols per second
	localparam int FRAME_SYMBOLS = 100;

	// Enough to count positions 0 to 99
	localparam int POS_WIDTH = 7;

	// --------------------------------------------------
	// Enumerations
	// --------------------------------------------------

	// Symbol drawn in one period, high time 2/10, 5/10 or 8/10
	typedef enum logic [1:0] {
		SYM_ZERO = 2'd0,
		SYM_ONE  = 2'd1,
		SYM_MARK = 2'd2
	} symbol_e;

	// Frame sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE = 2'd0,
		SEQ_LOAD = 2'd1,
		SEQ_RUN  = 2'd2
	} seq_state_e;

	// --------------------------------------------------
	// Time of year, BCD, units digit in the low bits
	// --------------------------------------------------
	typedef struct packed {
		logic [9:0] days_bcd;     // Hundreds 2, tens 4, units 4
		logic [5:0] hours_bcd;    // Tens 2, units 4
		logic [6:0] minutes_bcd;  // Tens 3, units 4
		logic [6:0] seconds_bcd;  // Tens 3, units 4
	} irig_time_t;

endpackage
